/* build.f */
cop_pkg.sv
cop_idecode.sv
cop_cprs.sv
cop_palu.sv
cop_rng.sv
cop_ctrl.sv
cop_top.sv
tb_cop_top.sv

/* Makefile */
TOP := tb_cop_top

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run $(TOP)"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

obj_dir/V$(TOP): build.f $(wildcard *.sv)
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" sim.log; then echo "NO RESULT"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir sim.log

/* tb_cop_top.sv */
// Assumes 16 CPRs and one instruction in flight with a fixed random seed
`timescale 1ns/1ps
`default_nettype none

module tb_cop_top;

    import cop_pkg::*;

    localparam int          CLK_PERIOD     = 40;
    localparam logic [31:0] RESET_SEED     = 32'h0000ace1; // Nondefault LFSR reset value
    localparam int          N_RANDOM       = 400;
    localparam int          N_DIRECTED_MAX = 100;          // Upper bound on directed instructions
    localparam int          WATCHDOG_NS    = (N_RANDOM + N_DIRECTED_MAX) * 10 * CLK_PERIOD;
    localparam int          ACK_TIMEOUT    = 8;            // Cycles to wait for cop_insn_ack

    logic      g_clk;
    logic      g_resetn;
    logic      cpu_insn_req;
    logic      cop_insn_ack;
    cop_insn_t cpu_insn;
    logic      cop_insn_rsp;
    logic      cpu_insn_ack;
    cop_rsp_t  cop_rsp;

    logic [31:0] cpr_model [16];   // Expected CPR contents
    logic [31:0] lfsr_model;       // Expected LFSR state
    cop_rsp_t    exp_q [$];        // Responses owed by the DUT
    string       name_q [$];       // Test name per owed response
    cop_rsp_t    held_rsp;         // First value of current response
    logic        rsp_held = 1'b0;

    cop_top #(.NUM_CPRS(16), .RNG_RESET_SEED(RESET_SEED)) i_dut (
        .g_clk, .g_resetn, .cpu_insn_req, .cop_insn_ack, .cpu_insn,
        .cop_insn_rsp, .cpu_insn_ack, .cop_rsp
    );

    initial g_clk = 1'b0;
    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic string format_rsp(input cop_rsp_t r);
        return $sformatf("wen=%0b waddr=%0d wdata=%h result=%0d",
                         r.wen, r.waddr, r.wdata, r.result);
    endfunction

    task automatic check_rsp(input string name, input cop_rsp_t exp, input cop_rsp_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %s, actual %s",
                                name, format_rsp(exp), format_rsp(act)));
        end
    endtask

    task automatic check_handshake(input string name, input logic exp_ack, input logic exp_rsp);
        if (cop_insn_ack !== exp_ack || cop_insn_rsp !== exp_rsp) begin
            abort_run($sformatf("[ERROR] %s: expected ack=%0b rsp=%0b, actual ack=%0b rsp=%0b",
                                name, exp_ack, exp_rsp, cop_insn_ack, cop_insn_rsp));
        end
    endtask

    // Builds a legal word with the reserved top bits zero
    function automatic logic [31:0] make_insn(input logic [4:0] op, input logic [2:0] pw,
                                              input logic [4:0] rd, input logic [3:0] crs1,
                                              input logic [3:0] crs2);
        cop_enc_t f;
        f.zero   = 4'h0;
        f.crs2   = crs2;
        f.crs1   = crs1;
        f.op     = op;
        f.pw     = pw;
        f.rd     = rd;
        f.opcode = COP_OPCODE;
        return f;
    endfunction

    // Each lane adds or subtracts and wraps on its own
    function automatic logic [31:0] lane_arith(input logic [31:0] a, input logic [31:0] b,
                                               input logic [2:0] pw, input logic sub);
        int          width;
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] r;
        logic [63:0] acc;
        width = 32 >> pw;                  // 32, 16, 8, 4, 2
        mask  = (64'd1 << width) - 64'd1;
        acc   = '0;
        for (int l = 0; l < 32 / width; l++) begin
            la  = ({32'h0, a} >> (l * width)) & mask;
            lb  = ({32'h0, b} >> (l * width)) & mask;
            r   = sub ? la - lb : la + lb;
            acc = acc | ((r & mask) << (l * width));
        end
        return acc[31:0];
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? LFSR_TAPS : 32'h0); // Taps fold in when a 1 shifts out
    endfunction

    // Updates the CPR and LFSR model and returns the owed response
    function automatic cop_rsp_t model_exec(input logic [31:0] word, input logic [31:0] rs1);
        cop_rsp_t    rsp;
        logic [4:0]  op;
        logic [2:0]  pw;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic        bad;
        op  = word[19:15];
        pw  = word[14:12];
        rd  = word[11:7];
        a   = cpr_model[word[23:20]]; // Operands read before any write
        b   = cpr_model[word[27:24]];
        bad = (word[6:0] != COP_OPCODE) || (word[31:28] != 4'h0);
        case (op)
            OP_PADD, OP_PSUB:                 bad = bad || (pw > 3'd4);
            OP_XOR, OP_AND, OP_OR, OP_GPR2XCR,
            OP_XCR2GPR, OP_RSEED, OP_RSAMP:   bad = bad;
            default:                          bad = 1'b1; // Unknown op
        endcase
        rsp        = '0;
        rsp.waddr  = rd;
        rsp.result = bad ? RES_BAD_INS : RES_SUCCESS;
        if (!bad) begin
            case (op)
                OP_PADD:    cpr_model[rd[3:0]] = lane_arith(a, b, pw, 1'b0);
                OP_PSUB:    cpr_model[rd[3:0]] = lane_arith(a, b, pw, 1'b1);
                OP_XOR:     cpr_model[rd[3:0]] = a ^ b;
                OP_AND:     cpr_model[rd[3:0]] = a & b;
                OP_OR:      cpr_model[rd[3:0]] = a | b;
                OP_GPR2XCR: cpr_model[rd[3:0]] = rs1;
                OP_XCR2GPR: begin
                    rsp.wen   = 1'b1;
                    rsp.wdata = a;
                end
                OP_RSEED:   lfsr_model = (a == 32'h0) ? RESET_SEED : a;
                OP_RSAMP: begin
                    cpr_model[rd[3:0]] = lfsr_model; // Sample before the step
                    lfsr_model         = lfsr_next(lfsr_model);
                end
                default: ;
            endcase
        end
        return rsp;
    endfunction

    // Mostly legal words with about 1 in 8 corrupted
    function automatic logic [31:0] random_word();
        cop_enc_t f;
        f = make_insn(5'($urandom_range(0, 8)), 3'($urandom_range(0, 4)),
                      5'($urandom_range(0, 31)), 4'($urandom_range(0, 15)),
                      4'($urandom_range(0, 15)));
        if (f.op != OP_PADD && f.op != OP_PSUB) begin
            f.pw = 3'($urandom_range(0, 7)); // Ignored outside packed arithmetic
        end
        if ($urandom_range(0, 7) == 0) begin
            case ($urandom_range(0, 3))
                0: f.opcode = f.opcode ^ 7'($urandom_range(1, 127));
                1: f.zero   = 4'($urandom_range(1, 15));
                2: f.op     = 5'($urandom_range(9, 31));
                default: begin
                    f.op = ($urandom_range(0, 1) == 1) ? OP_PSUB : OP_PADD;
                    f.pw = 3'($urandom_range(5, 7)); // Reserved pack width
                end
            endcase
        end
        return f;
    endfunction

    // Entered and left just after a falling edge
    task automatic run_insn(input string name, input logic [31:0] word, input logic [31:0] rs1);
        int waited;
        int delay;
        waited       = 0;
        cpu_insn_req = 1'b1;
        cpu_insn     = {word, rs1};
        while (!cop_insn_ack) begin
            @(negedge g_clk);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                abort_run($sformatf("%s: coprocessor never acknowledged the request", name));
            end
        end
        exp_q.push_back(model_exec(word, rs1)); // Accept happens at the next rising edge
        name_q.push_back(name);
        @(negedge g_clk);
        cpu_insn_req = 1'b0;
        cpu_insn     = '0;
        check_handshake(name, 1'b0, 1'b1); // Response one cycle after accept
        delay = $urandom_range(0, 3);
        repeat (delay) begin
            @(negedge g_clk);
            check_handshake(name, 1'b0, 1'b1); // Response held under back-pressure
        end
        cpu_insn_ack = 1'b1;
        @(negedge g_clk);
        cpu_insn_ack = 1'b0;
        check_handshake(name, 1'b1, 1'b0); // Ready again after retire
    endtask

    task automatic read_cpr(input string name, input logic [3:0] crs1);
        run_insn(name, make_insn(OP_XCR2GPR, PW_32, 5'($urandom_range(0, 31)), crs1, 4'h0),
                 $urandom());
    endtask

    // Checks each response on its first cycle, then that it holds
    always @(negedge g_clk) begin
        if (g_resetn && cop_insn_rsp) begin
            if (!rsp_held) begin
                if (exp_q.size() == 0) begin
                    abort_run("DUT raised a response with no instruction accepted");
                end else begin
                    check_rsp(name_q.pop_front(), exp_q.pop_front(), cop_rsp);
                end
                held_rsp = cop_rsp;
                rsp_held = 1'b1;
            end else begin
                check_rsp("response held", held_rsp, cop_rsp);
            end
        end else begin
            rsp_held = 1'b0;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Watchdog timeout, the run took longer than its tests allow");
    end

    initial begin
        logic [31:0] bad_words [5];
        void'($urandom(32'hc500));
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn     = '0;
        cpu_insn_ack = 1'b0;
        foreach (cpr_model[i]) begin
            cpr_model[i] = 32'h0;
        end
        lfsr_model = RESET_SEED;
        repeat (2) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        check_handshake("reset", 1'b0, 1'b0);
        check_rsp("reset", '0, cop_rsp);
        @(negedge g_clk);
        check_handshake("ack after reset", 1'b1, 1'b0);
        for (int i = 0; i < 16; i++) begin
            run_insn("gpr2xcr load", make_insn(OP_GPR2XCR, PW_32, 5'(i), 4'h0, 4'h0), $urandom());
        end
        for (int i = 0; i < 16; i++) begin
            read_cpr("xcr2gpr readback", 4'(i));
        end
        for (int p = 0; p < 5; p++) begin   // Every legal pack width
            run_insn("packed add", make_insn(OP_PADD, 3'(p), 5'd14, 4'd1, 4'd2), 32'h0);
            read_cpr("packed add readback", 4'd14);
            run_insn("packed sub", make_insn(OP_PSUB, 3'(p), 5'd14, 4'd3, 4'd4), 32'h0);
            read_cpr("packed sub readback", 4'd14);
        end
        run_insn("xor", make_insn(OP_XOR, PW_32, 5'd13, 4'd5, 4'd6), 32'h0);
        read_cpr("xor readback", 4'd13);
        run_insn("and", make_insn(OP_AND, PW_32, 5'd13, 4'd7, 4'd8), 32'h0);
        read_cpr("and readback", 4'd13);
        run_insn("or", make_insn(OP_OR, PW_32, 5'd13, 4'd9, 4'd10), 32'h0);
        read_cpr("or readback", 4'd13);
        run_insn("rsamp after reset", make_insn(OP_RSAMP, PW_32, 5'd12, 4'd0, 4'd0), 32'h0);
        read_cpr("rsamp after reset readback", 4'd12);
        run_insn("rseed", make_insn(OP_RSEED, PW_32, 5'd0, 4'd5, 4'd0), 32'h0);
        repeat (6) begin
            run_insn("rsamp", make_insn(OP_RSAMP, PW_32, 5'd12, 4'd0, 4'd0), 32'h0);
            read_cpr("rsamp readback", 4'd12);
        end
        run_insn("zero into cpr", make_insn(OP_GPR2XCR, PW_32, 5'd15, 4'd0, 4'd0), 32'h0);
        run_insn("rseed zero", make_insn(OP_RSEED, PW_32, 5'd0, 4'd15, 4'd0), 32'h0);
        run_insn("rsamp after zero seed", make_insn(OP_RSAMP, PW_32, 5'd12, 4'd0, 4'd0), 32'h0);
        read_cpr("zero seed readback", 4'd12);
        bad_words[0] = make_insn(OP_XOR, PW_32, 5'd4, 4'd1, 4'd2) ^ 32'h1;         // Opcode
        bad_words[1] = make_insn(OP_XOR, PW_32, 5'd4, 4'd1, 4'd2) | 32'h1000_0000; // Reserved bits
        bad_words[2] = make_insn(5'd9, PW_32, 5'd4, 4'd1, 4'd2);                   // Unknown op
        bad_words[3] = make_insn(OP_PADD, 3'd5, 5'd4, 4'd1, 4'd2);                 // Bad pw
        bad_words[4] = make_insn(OP_XCR2GPR, PW_32, 5'd4, 4'd1, 4'd0) | 32'h8000_0000; // Read
        foreach (bad_words[i]) begin
            run_insn("illegal encoding", bad_words[i], $urandom());
            read_cpr("cpr after illegal", 4'd4);
        end
        repeat (N_RANDOM) begin
            run_insn("random", random_word(), $urandom());
        end
        @(negedge g_clk);
        if (exp_q.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("Responses still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire

/* cop_top.sv */
// Co-processor top; NUM_CPRS is a power of two up to 16, higher crs/crd bits are dropped
`timescale 1ns/1ps
`default_nettype none

module cop_top #(
    parameter int          NUM_CPRS       = 16,
    parameter logic [31:0] RNG_RESET_SEED = 32'h1
) (
    input  wire logic               g_clk,
    input  wire logic               g_resetn,     // Sync, active low
    input  wire logic               cpu_insn_req,
    output logic                    cop_insn_ack,
    input  wire cop_pkg::cop_insn_t cpu_insn,     // Encoding and GPR rs1
    output logic                    cop_insn_rsp,
    input  wire logic               cpu_insn_ack,
    output cop_pkg::cop_rsp_t       cop_rsp
);

    import cop_pkg::*;

    localparam int CPR_AW = $clog2(NUM_CPRS);

    cop_insn_t   cur_insn;
    cop_dec_t    dec;
    logic        insn_valid;
    logic        is_palu_op;
    logic        is_rng_op;
    logic        palu_valid;
    logic        rng_valid;
    cop_wb_t     palu_wb;
    cop_wb_t     rng_wb;
    cop_wb_t     wb;          // Merged writeback
    logic [31:0] crs1_rdata;
    logic [31:0] crs2_rdata;

    always_comb begin
        is_palu_op = 1'b0;
        is_rng_op  = 1'b0;
        case (dec.op)
            OP_PADD, OP_PSUB, OP_XOR, OP_AND, OP_OR,
            OP_GPR2XCR, OP_XCR2GPR: is_palu_op = 1'b1;
            OP_RSEED, OP_RSAMP:     is_rng_op  = 1'b1;
            default:                ;
        endcase
    end

    // Illegal instructions reach no unit, so nothing is written
    assign palu_valid = insn_valid && !dec.illegal && is_palu_op;
    assign rng_valid  = insn_valid && !dec.illegal && is_rng_op;

    assign wb = palu_wb | rng_wb; // Idle units drive zero

    cop_ctrl i_ctrl (
        .g_clk, .g_resetn, .cpu_insn_req, .cop_insn_ack, .cpu_insn,
        .cop_insn_rsp, .cpu_insn_ack, .cop_rsp,
        .illegal(dec.illegal), .gpr_wb(wb), .cur_insn, .insn_valid
    );

    cop_idecode i_idecode (.insn(cur_insn.enc), .dec);

    cop_cprs #(.NUM_CPRS(NUM_CPRS)) i_cprs (
        .g_clk, .g_resetn,
        .rs1_addr(dec.crs1[CPR_AW-1:0]), .rs2_addr(dec.crs2[CPR_AW-1:0]),
        .wen(wb.cpr_wen), .waddr(dec.crd[CPR_AW-1:0]), .wdata(wb.cpr_wdata),
        .rs1_rdata(crs1_rdata), .rs2_rdata(crs2_rdata)
    );

    cop_palu i_palu (
        .valid(palu_valid), .dec, .crs1_rdata, .crs2_rdata,
        .gpr_rs1(cur_insn.rs1), .wb(palu_wb)
    );

    cop_rng #(.RNG_RESET_SEED(RNG_RESET_SEED)) i_rng (
        .g_clk, .g_resetn, .valid(rng_valid), .dec, .crs1_rdata, .wb(rng_wb)
    );

endmodule

`default_nettype wire

/* cop_ctrl.sv */
// One instruction in flight; all units finish in the accept cycle, cpu_insn must be held while req
`timescale 1ns/1ps
`default_nettype none

module cop_ctrl (
    input  wire logic               g_clk,
    input  wire logic               g_resetn,
    input  wire logic               cpu_insn_req, // CPU has an instruction
    output logic                    cop_insn_ack, // Ready to accept
    input  wire cop_pkg::cop_insn_t cpu_insn,
    output logic                    cop_insn_rsp, // Response valid
    input  wire logic               cpu_insn_ack, // CPU took the response
    output cop_pkg::cop_rsp_t       cop_rsp,
    input  wire logic               illegal,      // From decoder
    input  wire cop_pkg::cop_wb_t   gpr_wb,       // Merged unit writeback
    output cop_pkg::cop_insn_t      cur_insn,     // To decoder and units
    output logic                    insn_valid    // Accept cycle strobe
);

    import cop_pkg::*;

    cop_state_e state;
    cop_state_e state_nxt;
    logic       accept;   // Request meets ack
    logic       retire;   // Response meets ack
    cop_insn_t  r_insn;   // Held instruction

    assign cop_insn_ack = (state == ST_WAITING);
    assign cop_insn_rsp = (state == ST_FINISHED);

    assign accept     = cpu_insn_req && cop_insn_ack;
    assign retire     = cop_insn_rsp && cpu_insn_ack;
    assign insn_valid = accept;

    // Live input while accepting, captured copy afterwards
    assign cur_insn = accept ? cpu_insn : r_insn;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                state_nxt = ST_WAITING; // Ack rises one cycle after reset
            end
            ST_WAITING: begin
                if (accept) begin
                    state_nxt = ST_FINISHED; // Result is ready at once
                end
            end
            ST_FINISHED: begin
                if (retire) begin
                    state_nxt = ST_WAITING;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            r_insn <= cpu_insn;
        end
    end

    // Response register, stable for the whole FINISHED state
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cop_rsp <= '0;
        end else if (accept) begin
            cop_rsp.wen    <= gpr_wb.gpr_wen && !illegal;
            cop_rsp.waddr  <= cur_insn.enc.rd;
            cop_rsp.wdata  <= illegal ? 32'h0 : gpr_wb.gpr_wdata;
            cop_rsp.result <= illegal ? RES_BAD_INS : RES_SUCCESS;
        end
    end

endmodule

`default_nettype wire

/* cop_rng.sv */
// LFSR is a test-quality generator, not a TRNG; a zero seed is replaced by RNG_RESET_SEED
`timescale 1ns/1ps
`default_nettype none

module cop_rng #(
    parameter logic [31:0] RNG_RESET_SEED = 32'h1
) (
    input  wire logic              g_clk,
    input  wire logic              g_resetn,
    input  wire logic              valid,       // Dispatched this cycle
    input  wire cop_pkg::cop_dec_t dec,
    input  wire logic [31:0]       crs1_rdata,  // Seed source
    output cop_pkg::cop_wb_t       wb
);

    import cop_pkg::*;

    logic [31:0] lfsr;      // Current state
    logic [31:0] lfsr_step; // State after one shift
    logic [31:0] seed;      // Seed with zero guarded

    // Shift right, fold taps back in on a 1 out
    assign lfsr_step = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
    assign seed      = (crs1_rdata == 32'h0) ? RNG_RESET_SEED : crs1_rdata;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lfsr <= RNG_RESET_SEED;
        end else if (valid && dec.op == OP_RSEED) begin
            lfsr <= seed;
        end else if (valid && dec.op == OP_RSAMP) begin
            lfsr <= lfsr_step; // Advance after sampling
        end
    end

    always_comb begin
        wb = '0;
        if (valid && dec.op == OP_RSAMP) begin
            wb.cpr_wen   = 1'b1;
            wb.cpr_wdata = lfsr; // Pre-step value
        end
    end

endmodule

`default_nettype wire

/* cop_palu.sv */
// Single-cycle combinational unit; wb is all zero unless valid, so it can be ORed with others
`timescale 1ns/1ps
`default_nettype none

module cop_palu (
    input  wire logic              valid,       // Dispatched this cycle
    input  wire cop_pkg::cop_dec_t dec,
    input  wire logic [31:0]       crs1_rdata,
    input  wire logic [31:0]       crs2_rdata,
    input  wire logic [31:0]       gpr_rs1,     // GPR source for GPR2XCR
    output cop_pkg::cop_wb_t       wb
);

    import cop_pkg::*;

    logic [4:0]  lane_mask; // Lane width minus one
    logic        sub;       // Subtract: invert b, carry in 1
    logic [31:0] b_in;      // Possibly inverted operand b
    logic [31:0] psum;      // Lanewise sum or difference

    always_comb begin
        case (dec.pw)
            PW_16:   lane_mask = 5'd15;
            PW_8:    lane_mask = 5'd7;
            PW_4:    lane_mask = 5'd3;
            PW_2:    lane_mask = 5'd1;
            default: lane_mask = 5'd31;
        endcase
    end

    assign sub  = (dec.op == OP_PSUB);
    assign b_in = sub ? ~crs2_rdata : crs2_rdata;

    // Ripple adder whose carry restarts at every lane boundary
    always_comb begin : packed_add
        logic carry;
        carry = 1'b0;
        psum  = 32'h0;
        for (int i = 0; i < 32; i++) begin
            if ((i[4:0] & lane_mask) == 5'd0) begin
                carry = sub; // Lane LSB, no carry across lanes
            end
            psum[i] = crs1_rdata[i] ^ b_in[i] ^ carry;
            carry   = (crs1_rdata[i] & b_in[i]) | (carry & (crs1_rdata[i] ^ b_in[i]));
        end
    end

    always_comb begin
        wb = '0;
        if (valid) begin
            wb.cpr_wen = 1'b1; // Most ops write crd
            case (dec.op)
                OP_PADD, OP_PSUB: wb.cpr_wdata = psum;
                OP_XOR:           wb.cpr_wdata = crs1_rdata ^ crs2_rdata;
                OP_AND:           wb.cpr_wdata = crs1_rdata & crs2_rdata;
                OP_OR:            wb.cpr_wdata = crs1_rdata | crs2_rdata;
                OP_GPR2XCR:       wb.cpr_wdata = gpr_rs1;
                OP_XCR2GPR: begin
                    wb.cpr_wen   = 1'b0; // GPR write only
                    wb.gpr_wen   = 1'b1;
                    wb.gpr_wdata = crs1_rdata;
                end
                default:          wb.cpr_wen = 1'b0; // Not a PALU op
            endcase
        end
    end

endmodule

`default_nettype wire

/* cop_cprs.sv */
// NUM_CPRS must be a power of two up to 16; reads are asynchronous, a write shows next cycle
`timescale 1ns/1ps
`default_nettype none

module cop_cprs #(
    parameter int NUM_CPRS = 16,
    localparam int AW      = $clog2(NUM_CPRS)
) (
    input  wire logic          g_clk,
    input  wire logic          g_resetn,
    input  wire logic [AW-1:0] rs1_addr,  // Read port 1
    input  wire logic [AW-1:0] rs2_addr,  // Read port 2
    input  wire logic          wen,       // Write port
    input  wire logic [AW-1:0] waddr,
    input  wire logic [31:0]   wdata,
    output logic [31:0]        rs1_rdata,
    output logic [31:0]        rs2_rdata
);

    logic [31:0] regs [NUM_CPRS]; // Register array

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < NUM_CPRS; i++) begin
                regs[i] <= 32'h0; // Architectural zero after reset
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    assign rs1_rdata = regs[rs1_addr];
    assign rs2_rdata = regs[rs2_addr];

endmodule

`default_nettype wire

/* cop_idecode.sv */
// Purely combinational; fields are valid for any word, only dec.illegal says whether to use them
`timescale 1ns/1ps
`default_nettype none

module cop_idecode (
    input  wire logic [31:0]      insn, // Raw instruction word
    output cop_pkg::cop_dec_t     dec   // Decoded fields and legality
);

    import cop_pkg::*;

    cop_enc_t enc;      // Field view of insn
    logic     op_known; // Op is one of the defined ops
    logic     pw_legal; // Pack width is defined
    logic     is_pack;  // Op uses the pack width

    assign enc = insn;

    always_comb begin
        case (cop_op_e'(enc.op))
            OP_PADD, OP_PSUB, OP_XOR, OP_AND, OP_OR,
            OP_GPR2XCR, OP_XCR2GPR, OP_RSEED, OP_RSAMP: op_known = 1'b1;
            default:                                    op_known = 1'b0;
        endcase
    end

    always_comb begin
        case (cop_pw_e'(enc.pw))
            PW_32, PW_16, PW_8, PW_4, PW_2: pw_legal = 1'b1;
            default:                        pw_legal = 1'b0;
        endcase
    end

    // Only packed arithmetic cares about pw
    assign is_pack = (enc.op == OP_PADD) || (enc.op == OP_PSUB);

    always_comb begin
        dec.illegal = (enc.opcode != COP_OPCODE) ||  // Not ours
                      (enc.zero != 4'd0)         ||  // Reserved bits set
                      !op_known                  ||
                      (is_pack && !pw_legal);
        dec.op      = cop_op_e'(enc.op);
        dec.pw      = cop_pw_e'(enc.pw);
        dec.crd     = enc.rd[3:0];                   // CPR dest shares rd field
        dec.rd      = enc.rd;
        dec.crs1    = enc.crs1;
        dec.crs2    = enc.crs2;
    end

endmodule

`default_nettype wire

/* cop_pkg.sv */
// Shared types for the crypto co-processor; encoding is local to this design, not the ISE spec
`default_nettype none

package cop_pkg;

    localparam logic [6:0]  COP_OPCODE = 7'b0101011;   // Major opcode, bits 6:0
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003; // Galois feedback mask

    // Operation field, bits 19:15
    typedef enum logic [4:0] {
        OP_PADD    = 5'd0,  // Packed add
        OP_PSUB    = 5'd1,  // Packed subtract
        OP_XOR     = 5'd2,
        OP_AND     = 5'd3,
        OP_OR      = 5'd4,
        OP_GPR2XCR = 5'd5,  // GPR rs1 -> crd
        OP_XCR2GPR = 5'd6,  // crs1 -> GPR rd
        OP_RSEED   = 5'd7,  // Seed LFSR from crs1
        OP_RSAMP   = 5'd8   // LFSR sample -> crd
    } cop_op_e;

    // Pack width field, bits 14:12
    typedef enum logic [2:0] {
        PW_32 = 3'd0,
        PW_16 = 3'd1,
        PW_8  = 3'd2,
        PW_4  = 3'd3,
        PW_2  = 3'd4        // 5..7 reserved
    } cop_pw_e;

    typedef enum logic [2:0] {
        RES_SUCCESS = 3'd0,
        RES_BAD_INS = 3'd1
    } cop_result_e;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0, // Out of reset
        ST_WAITING  = 2'd1, // Ready for a request
        ST_FINISHED = 2'd2  // Response held until acked
    } cop_state_e;

    // Raw instruction word, MSB first
    typedef struct packed {
        logic [3:0] zero;   // Must be zero
        logic [3:0] crs2;
        logic [3:0] crs1;
        logic [4:0] op;
        logic [2:0] pw;
        logic [4:0] rd;     // GPR rd, low 4 bits are crd
        logic [6:0] opcode;
    } cop_enc_t;

    typedef struct packed {
        cop_enc_t    enc;   // Instruction encoding
        logic [31:0] rs1;   // GPR rs1 value
    } cop_insn_t;

    typedef struct packed {
        logic       illegal;
        cop_op_e    op;
        cop_pw_e    pw;
        logic [3:0] crd;
        logic [4:0] rd;
        logic [3:0] crs1;
        logic [3:0] crs2;
    } cop_dec_t;

    typedef struct packed {
        logic        wen;   // GPR write back
        logic [4:0]  waddr;
        logic [31:0] wdata;
        cop_result_e result;
    } cop_rsp_t;

    // Per-unit writeback request, zero when idle so units can be ORed
    typedef struct packed {
        logic        cpr_wen;
        logic [31:0] cpr_wdata;
        logic        gpr_wen;
        logic [31:0] gpr_wdata;
    } cop_wb_t;

endpackage

`default_nettype wire
